// ==== design/ulpi_decoder.sv ====
module ulpi_decoder
  import usb_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        ulpi_dir_i,
  input  logic        ulpi_nxt_i,
  input  logic [7:0]  ulpi_data_i,

  output logic        crc_error_o,
  output logic        crc_valid_o,
  output logic        sof_recv_o,
  output logic [10:0] sof_frame_o,
  output logic        dec_idle_o,

  output logic        tok_recv_o,
  output logic        tok_ping_o,
  output logic [6:0]  tok_addr_o,
  output logic [3:0]  tok_endp_o,
  output logic        hsk_recv_o,
  output logic        usb_recv_o,

  output logic        m_tvalid_o,
  output logic        m_tkeep_o,
  output logic        m_tlast_o,
  output pid_e        m_tuser_o,
  output logic [7:0]  m_tdata_o
);

  // RX_CMD bits 5:4 while a receive is in progress
  localparam logic [1:0] RX_ACTIVE = 2'b01;

  logic        dir_q;
  logic        pid_wait_q;
  logic        cyc_q;
  pid_e        pid_q;
  pid_type_e   ptype_w;
  logic        beat_w;
  logic        rx_end_w;
  logic        pid_vld_w;
  logic        end_w;
  logic        is_sof_w;
  logic        is_tok_w;
  logic        is_hsk_w;
  logic        is_dat_w;

  logic        stb_q;
  logic [7:0]  cap_q;
  logic        vld_q;
  logic [7:0]  out_q;
  logic        keep_w;

  token_body_u body_w;
  logic        crc5_ok_w;
  logic [15:0] crc16_q;
  logic        crc16_ok_w;

  logic        tok_recv_q;
  logic        tok_ping_q;
  logic        sof_recv_q;
  logic        hsk_recv_q;
  logic        usb_recv_q;
  logic        crc_valid_q;
  logic        crc_error_q;
  logic [6:0]  addr_q;
  logic [3:0]  endp_q;
  logic [10:0] frame_q;

  logic        tvalid_q;
  logic        tkeep_q;
  logic        tlast_q;
  logic [7:0]  tdata_q;

  // A data beat needs dir high for a cycle already, which skips the turnaround
  assign beat_w    = ulpi_dir_i && dir_q && ulpi_nxt_i;
  assign rx_end_w  = !ulpi_dir_i || (!ulpi_nxt_i && ulpi_data_i[5:4] != RX_ACTIVE);
  assign pid_vld_w = beat_w && pid_wait_q && (ulpi_data_i[3:0] == ~ulpi_data_i[7:4]);
  assign end_w     = cyc_q && rx_end_w;

  assign ptype_w  = pid_type_e'(pid_q[1:0]);
  assign is_sof_w = pid_q == PID_SOF;
  assign is_tok_w = ptype_w == PTYPE_TOKEN || pid_q == PID_PING;
  assign is_hsk_w = ptype_w == PTYPE_HANDSHAKE;
  assign is_dat_w = ptype_w == PTYPE_DATA;

  // Packet framing
  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q      <= 1'b0;
      pid_wait_q <= 1'b0;
      cyc_q      <= 1'b0;
      pid_q      <= PID_RESERVED;
    end else begin
      dir_q <= ulpi_dir_i;
      // Only the first data byte after the turnaround can be a PID
      if (ulpi_dir_i && !dir_q) begin
        pid_wait_q <= 1'b1;
      end else if (beat_w || !ulpi_dir_i) begin
        pid_wait_q <= 1'b0;
      end
      if (rx_end_w) begin
        cyc_q <= 1'b0;
      end else if (pid_vld_w) begin
        cyc_q <= 1'b1;
      end
      if (pid_vld_w) begin
        pid_q <= pid_e'(ulpi_data_i[3:0]);
      end
    end
  end

  // Stage one, capture on every data beat; the PID beat leaves stb_q low
  always_ff @(posedge clock) begin
    if (reset) begin
      stb_q <= 1'b0;
    end else if (beat_w) begin
      stb_q <= cyc_q;
    end else if (rx_end_w) begin
      stb_q <= 1'b0;
    end
  end

  // Stage two, holds the byte before the captured one
  always_ff @(posedge clock) begin
    if (reset || rx_end_w) begin
      vld_q <= 1'b0;
    end else if (beat_w) begin
      vld_q <= stb_q;
    end
  end

  always_ff @(posedge clock) begin
    if (beat_w) begin
      cap_q <= ulpi_data_i;
      out_q <= cap_q;
    end
  end

  // At the end of a token the last two bytes are its body
  assign body_w    = {cap_q, out_q};
  assign crc5_ok_w = crc5({body_w.tok.endp, body_w.tok.addr}) == body_w.tok.crc5;

  // CRC16 over every byte after the PID
  always_ff @(posedge clock) begin
    if (!cyc_q) begin
      crc16_q <= 16'hFFFF;
    end else if (beat_w) begin
      crc16_q <= crc16(ulpi_data_i, crc16_q);
    end
  end

  assign crc16_ok_w = crc16_q == CRC16_RESIDUE;

  // End-of-packet strobes; PING also counts as a received token
  always_ff @(posedge clock) begin
    if (reset) begin
      tok_recv_q  <= 1'b0;
      tok_ping_q  <= 1'b0;
      sof_recv_q  <= 1'b0;
      hsk_recv_q  <= 1'b0;
      usb_recv_q  <= 1'b0;
      crc_valid_q <= 1'b0;
      crc_error_q <= 1'b0;
    end else begin
      tok_recv_q  <= end_w && is_tok_w && !is_sof_w && crc5_ok_w;
      tok_ping_q  <= end_w && pid_q == PID_PING && crc5_ok_w;
      sof_recv_q  <= end_w && is_sof_w && crc5_ok_w;
      hsk_recv_q  <= end_w && is_hsk_w;
      usb_recv_q  <= end_w && is_dat_w && crc16_ok_w;
      crc_valid_q <= end_w && ((is_tok_w && crc5_ok_w) || (is_dat_w && crc16_ok_w));
      // Error flag stays until the next packet that carries a CRC
      if (end_w && is_tok_w) begin
        crc_error_q <= !crc5_ok_w;
      end else if (end_w && is_dat_w) begin
        crc_error_q <= !crc16_ok_w;
      end
    end
  end

  // Token fields, updated only by a token with a good CRC5
  always_ff @(posedge clock) begin
    if (reset) begin
      addr_q  <= '0;
      endp_q  <= '0;
      frame_q <= '0;
    end else if (end_w && crc5_ok_w) begin
      if (is_sof_w) begin
        frame_q <= body_w.sof.frame;
      end else if (is_tok_w) begin
        addr_q <= body_w.tok.addr;
        endp_q <= body_w.tok.endp;
      end
    end
  end

  // Stage three, a byte leaves only once two newer bytes are held behind it
  assign keep_w = beat_w && stb_q && vld_q && is_dat_w;

  always_ff @(posedge clock) begin
    if (reset) begin
      tvalid_q <= 1'b0;
      tkeep_q  <= 1'b0;
      tlast_q  <= 1'b0;
    end else begin
      tvalid_q <= cyc_q;
      tkeep_q  <= keep_w;
      tlast_q  <= end_w && is_dat_w;
    end
  end

  always_ff @(posedge clock) begin
    if (keep_w) begin
      tdata_q <= out_q;
    end
  end

  assign crc_error_o = crc_error_q;
  assign crc_valid_o = crc_valid_q;
  assign sof_recv_o  = sof_recv_q;
  assign sof_frame_o = frame_q;
  assign dec_idle_o  = !cyc_q;
  assign tok_recv_o  = tok_recv_q;
  assign tok_ping_o  = tok_ping_q;
  assign tok_addr_o  = addr_q;
  assign tok_endp_o  = endp_q;
  assign hsk_recv_o  = hsk_recv_q;
  assign usb_recv_o  = usb_recv_q;

  assign m_tvalid_o = tvalid_q;
  assign m_tkeep_o  = tkeep_q;
  assign m_tlast_o  = tlast_q;
  assign m_tuser_o  = pid_q;
  assign m_tdata_o  = tdata_q;

endmodule

// ==== design/usb_pkg.sv ====
package usb_pkg;

  // PID codes as carried in the low nibble of the PID byte
  typedef enum logic [3:0] {
    PID_RESERVED = 4'b0000,
    PID_OUT      = 4'b0001,
    PID_IN       = 4'b1001,
    PID_SOF      = 4'b0101,
    PID_SETUP    = 4'b1101,
    PID_DATA0    = 4'b0011,
    PID_DATA1    = 4'b1011,
    PID_ACK      = 4'b0010,
    PID_NAK      = 4'b1010,
    PID_STALL    = 4'b1110,
    PID_PING     = 4'b0100
  } pid_e;

  // PID class from the two low PID bits
  typedef enum logic [1:0] {
    PTYPE_SPECIAL   = 2'b00,
    PTYPE_TOKEN     = 2'b01,
    PTYPE_HANDSHAKE = 2'b10,
    PTYPE_DATA      = 2'b11
  } pid_type_e;

  // Two bytes after a token PID, first received byte in bits 7:0
  typedef union packed {
    struct packed {
      logic [4:0] crc5;
      logic [3:0] endp;
      logic [6:0] addr;
    } tok;
    struct packed {
      logic [4:0]  crc5;
      logic [10:0] frame;
    } sof;
  } token_body_u;

  // Remainder left in the CRC16 register after a good packet and its CRC
  localparam logic [15:0] CRC16_RESIDUE = 16'h800D;

  // Token CRC5, polynomial x^5 + x^2 + 1, data taken LSB first
  function automatic logic [4:0] crc5(input logic [10:0] data);
    logic [4:0] lfsr;
    logic [4:0] result;
    logic       fb;
    lfsr = 5'b11111;
    for (int i = 0; i < 11; i++) begin
      fb   = lfsr[4] ^ data[i];
      lfsr = {lfsr[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
    end
    // Inverted remainder, bit order matching the field as it is sent
    for (int i = 0; i < 5; i++) begin
      result[i] = ~lfsr[4-i];
    end
    return result;
  endfunction

  // One byte step of the data CRC16, polynomial 8005, data taken LSB first
  function automatic logic [15:0] crc16(input logic [7:0] data, input logic [15:0] crc);
    logic [15:0] crc_next;
    logic        fb;
    crc_next = crc;
    for (int i = 0; i < 8; i++) begin
      fb       = crc_next[15] ^ data[i];
      crc_next = {crc_next[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
    end
    return crc_next;
  endfunction

endpackage

// ==== design/usb_rx_fifo.sv ====
module usb_rx_fifo
  import usb_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic       clock,
  input  logic       reset,

  input  logic       s_tvalid_i,
  input  logic       s_tkeep_i,
  input  logic       s_tlast_i,
  input  pid_e       s_tuser_i,
  input  logic [7:0] s_tdata_i,

  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tkeep_o,
  output logic       m_tlast_o,
  output pid_e       m_tuser_o,
  output logic [7:0] m_tdata_o,

  output logic       overflow_o
);

  localparam int DEPTH   = 1 << FIFO_DEPTH_LOG2;
  // Entry is PID, last, keep and data byte
  localparam int ENTRY_W = 14;

  logic [ENTRY_W-1:0]     mem_q [DEPTH];
  logic [FIFO_DEPTH_LOG2:0] wr_ptr_q;
  logic [FIFO_DEPTH_LOG2:0] rd_ptr_q;
  logic [ENTRY_W-1:0]     head_w;
  logic                   empty_w;
  logic                   full_w;
  logic                   wr_req_w;
  logic                   rd_w;
  logic                   overflow_q;

  assign empty_w  = wr_ptr_q == rd_ptr_q;
  assign full_w   = (wr_ptr_q[FIFO_DEPTH_LOG2] != rd_ptr_q[FIFO_DEPTH_LOG2]) &&
                    (wr_ptr_q[FIFO_DEPTH_LOG2-1:0] == rd_ptr_q[FIFO_DEPTH_LOG2-1:0]);
  assign wr_req_w = s_tvalid_i && (s_tkeep_i || s_tlast_i);
  assign rd_w     = !empty_w && m_tready_i;

  always_ff @(posedge clock) begin
    if (wr_req_w && !full_w) begin
      mem_q[wr_ptr_q[FIFO_DEPTH_LOG2-1:0]] <= {s_tuser_i, s_tlast_i, s_tkeep_i, s_tdata_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (wr_req_w && !full_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // The decoder cannot wait, so a beat into a full buffer is lost
      overflow_q <= wr_req_w && full_w;
    end
  end

  // Head entry falls through to the output
  assign head_w     = mem_q[rd_ptr_q[FIFO_DEPTH_LOG2-1:0]];
  assign m_tvalid_o = !empty_w;
  assign m_tdata_o  = head_w[7:0];
  assign m_tkeep_o  = !empty_w && head_w[8];
  assign m_tlast_o  = !empty_w && head_w[9];
  assign m_tuser_o  = empty_w ? PID_RESERVED : pid_e'(head_w[13:10]);
  assign overflow_o = overflow_q;

endmodule

// ==== design/usb_rx_top.sv ====
module usb_rx_top
  import usb_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic        clock,
  input  logic        reset,

  input  logic        ulpi_dir_i,
  input  logic        ulpi_nxt_i,
  input  logic [7:0]  ulpi_data_i,

  output logic        crc_error_o,
  output logic        crc_valid_o,
  output logic        sof_recv_o,
  output logic [10:0] sof_frame_o,
  output logic        tok_recv_o,
  output logic        tok_ping_o,
  output logic [6:0]  tok_addr_o,
  output logic [3:0]  tok_endp_o,
  output logic        hsk_recv_o,
  output logic        usb_recv_o,
  output logic        dec_idle_o,

  output logic        rx_tvalid_o,
  input  logic        rx_tready_i,
  output logic [7:0]  rx_tdata_o,
  output logic        rx_tkeep_o,
  output logic        rx_tlast_o,
  output pid_e        rx_tuser_o,

  output logic        overflow_o
);

  // Decoder stream, which never stalls
  logic       dec_tvalid;
  logic       dec_tkeep;
  logic       dec_tlast;
  pid_e       dec_tuser;
  logic [7:0] dec_tdata;

  ulpi_decoder i_ulpi_decoder (
    .clock       (clock),
    .reset       (reset),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_data_i (ulpi_data_i),
    .crc_error_o (crc_error_o),
    .crc_valid_o (crc_valid_o),
    .sof_recv_o  (sof_recv_o),
    .sof_frame_o (sof_frame_o),
    .dec_idle_o  (dec_idle_o),
    .tok_recv_o  (tok_recv_o),
    .tok_ping_o  (tok_ping_o),
    .tok_addr_o  (tok_addr_o),
    .tok_endp_o  (tok_endp_o),
    .hsk_recv_o  (hsk_recv_o),
    .usb_recv_o  (usb_recv_o),
    .m_tvalid_o  (dec_tvalid),
    .m_tkeep_o   (dec_tkeep),
    .m_tlast_o   (dec_tlast),
    .m_tuser_o   (dec_tuser),
    .m_tdata_o   (dec_tdata)
  );

  usb_rx_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) i_usb_rx_fifo (
    .clock      (clock),
    .reset      (reset),
    .s_tvalid_i (dec_tvalid),
    .s_tkeep_i  (dec_tkeep),
    .s_tlast_i  (dec_tlast),
    .s_tuser_i  (dec_tuser),
    .s_tdata_i  (dec_tdata),
    .m_tvalid_o (rx_tvalid_o),
    .m_tready_i (rx_tready_i),
    .m_tkeep_o  (rx_tkeep_o),
    .m_tlast_o  (rx_tlast_o),
    .m_tuser_o  (rx_tuser_o),
    .m_tdata_o  (rx_tdata_o),
    .overflow_o (overflow_o)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the USB receive testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usb_rx_tb -f tb.f -o usb_rx_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/usb_rx_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation passed"

// ==== tb.f ====
design/usb_pkg.sv
design/ulpi_decoder.sv
design/usb_rx_fifo.sv
design/usb_rx_top.sv
verification/usb_rx_checker.sv
verification/usb_rx_tb.sv

// ==== verification/usb_rx_checker.sv ====
module usb_rx_checker
  import usb_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input logic       tok_recv_o,
  input logic       tok_ping_o,
  input logic       sof_recv_o,
  input logic       hsk_recv_o,
  input logic       usb_recv_o,
  input logic       crc_valid_o,
  input logic       crc_error_o,
  input logic       dec_idle_o,
  input logic       overflow_o,
  input logic       rx_tvalid_o,
  input logic       rx_tready_i,
  input logic [7:0] rx_tdata_o,
  input logic       rx_tkeep_o,
  input logic       rx_tlast_o,
  input pid_e       rx_tuser_o
);

  logic [5:0] strobe_w;

  assign strobe_w = {tok_recv_o, tok_ping_o, sof_recv_o, hsk_recv_o, usb_recv_o, crc_valid_o};

  // End-of-packet strobes last a single cycle
  for (genvar i = 0; i < 6; i++) begin : g_strobe
    assert property (@(posedge clock) disable iff (reset) strobe_w[i] |=> !strobe_w[i])
      else $error("Status strobe %0d held for more than one cycle", i);
  end

  assert property (@(posedge clock) disable iff (reset) !(crc_valid_o && crc_error_o))
    else $error("CRC valid and CRC error high together");

  // A stalled beat holds its contents
  assert property (@(posedge clock) disable iff (reset)
    rx_tvalid_o && !rx_tready_i |=> rx_tvalid_o && $stable(rx_tdata_o) &&
      $stable(rx_tkeep_o) && $stable(rx_tlast_o) && $stable(rx_tuser_o))
    else $error("Stream beat changed while stalled");

  assert property (@(posedge clock) $fell(reset) |-> !rx_tvalid_o && !overflow_o && dec_idle_o)
    else $error("Outputs active in the first cycle after reset");

endmodule

// ==== verification/usb_rx_tb.sv ====
module usb_rx_tb
  import usb_pkg::*;
();

  localparam int          FIFO_DEPTH_LOG2 = 4;
  localparam int          FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
  localparam int          NUM_PACKETS     = 37;
  localparam logic [31:0] SEED            = 32'h7059_48de;
  // RX_CMD with the receive-active code in bits 5:4
  localparam logic [7:0]  RX_CMD_ACTIVE   = 8'h10;

  typedef logic [7:0] byte_q_t [$];

  typedef struct packed {
    pid_e       pid;
    logic       last;
    logic       keep;
    logic [7:0] data;
  } beat_t;

  typedef struct packed {
    logic        tok;
    logic        ping;
    logic        sof;
    logic        hsk;
    logic        usb;
    logic        dat;
    logic        crc_valid;
    logic        has_crc;
    logic        crc_ok;
    logic [6:0]  addr;
    logic [3:0]  endp;
    logic [10:0] frame;
  } expect_t;

  logic        clock;
  logic        reset;
  logic        ulpi_dir_i;
  logic        ulpi_nxt_i;
  logic [7:0]  ulpi_data_i;
  logic        rx_tready_i;
  logic        crc_error_o;
  logic        crc_valid_o;
  logic        sof_recv_o;
  logic [10:0] sof_frame_o;
  logic        tok_recv_o;
  logic        tok_ping_o;
  logic [6:0]  tok_addr_o;
  logic [3:0]  tok_endp_o;
  logic        hsk_recv_o;
  logic        usb_recv_o;
  logic        dec_idle_o;
  logic        rx_tvalid_o;
  logic [7:0]  rx_tdata_o;
  logic        rx_tkeep_o;
  logic        rx_tlast_o;
  pid_e        rx_tuser_o;
  logic        overflow_o;

  string       test_name = "init";
  beat_t       exp_q [$];
  int          ready_mode = 0;
  logic        limit_fill = 1'b0;
  int          dropped = 0;
  int          ovf_cnt = 0;
  logic        exp_crc_err = 1'b0;
  logic [6:0]  exp_addr = '0;
  logic [3:0]  exp_endp = '0;
  logic [10:0] exp_frame = '0;

  usb_rx_top #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) i_usb_rx_top (.*);

  bind usb_rx_top usb_rx_checker i_usb_rx_checker (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // 0 keeps ready high, 1 toggles it at random, 2 holds it low
  initial begin
    rx_tready_i = 1'b1;
    forever begin
      @(posedge clock);
      #2;
      case (ready_mode)
        0: rx_tready_i = 1'b1;
        1: rx_tready_i = 1'($urandom % 2);
        default: rx_tready_i = 1'b0;
      endcase
    end
  end

  task automatic abort_run;
    $display("** FAIL **");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pid(input string what, input pid_e exp, input pid_e act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %s (%h), actual %s (%h)",
               test_name, what, exp.name(), exp, act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_token(input logic [6:0] exp_a, input logic [3:0] exp_e,
                             input logic [6:0] act_a, input logic [3:0] act_e);
    if (act_a !== exp_a || act_e !== exp_e) begin
      $display("** Error %s token: expected addr %h endp %h, actual addr %h endp %h",
               test_name, exp_a, exp_e, act_a, act_e);
      abort_run();
    end
  endtask

  task automatic check_frame(input logic [10:0] exp, input logic [10:0] act);
    if (act !== exp) begin
      $display("** Error %s frame: expected %h, actual %h", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // Expected flags, token fields and payload for one packet
  function automatic expect_t expected_packet(input logic [7:0] pid_byte, input byte_q_t body,
                                              output byte_q_t payload);
    expect_t     e;
    pid_e        pid;
    token_body_u tok;
    logic [15:0] crc;
    e = '0;
    payload = {};
    pid = pid_e'(pid_byte[3:0]);
    if (pid_byte[7:4] != ~pid_byte[3:0]) begin
      return e;
    end
    case (pid)
      PID_OUT, PID_IN, PID_SETUP, PID_PING, PID_SOF: begin
        tok = {body[1], body[0]};
        e.has_crc   = 1'b1;
        e.crc_ok    = crc5(tok.sof.frame) == tok.sof.crc5;
        e.crc_valid = e.crc_ok;
        if (pid == PID_SOF) begin
          e.sof   = e.crc_ok;
          e.frame = tok.sof.frame;
        end else begin
          e.tok  = e.crc_ok;
          e.ping = e.crc_ok && pid == PID_PING;
          e.addr = tok.tok.addr;
          e.endp = tok.tok.endp;
        end
      end
      PID_ACK, PID_NAK, PID_STALL: begin
        e.hsk = 1'b1;
      end
      PID_DATA0, PID_DATA1: begin
        e.dat     = 1'b1;
        e.has_crc = 1'b1;
        crc = 16'hFFFF;
        foreach (body[i]) begin
          crc = crc16(body[i], crc);
        end
        e.crc_ok    = crc == CRC16_RESIDUE;
        e.usb       = e.crc_ok;
        e.crc_valid = e.crc_ok;
        // Last two bytes are the CRC and never reach the stream
        for (int i = 0; i < body.size() - 2; i++) begin
          payload.push_back(body[i]);
        end
      end
      default: ;
    endcase
    return e;
  endfunction

  function automatic logic [7:0] pid_byte_of(input pid_e pid, input logic bad);
    return {~pid ^ {3'b000, bad}, pid};
  endfunction

  task automatic build_token_body(input logic [10:0] fields, input logic bad,
                                  output byte_q_t body);
    token_body_u u;
    u.sof.frame = fields;
    u.sof.crc5  = crc5(fields);
    if (bad) begin
      u.sof.crc5[2] = ~u.sof.crc5[2];
    end
    body = {};
    body.push_back(u[7:0]);
    body.push_back(u[15:8]);
  endtask

  task automatic build_data_body(input int len, input logic corrupt, output byte_q_t body);
    logic [15:0] crc;
    logic [7:0]  lo;
    logic [7:0]  hi;
    body = {};
    crc = 16'hFFFF;
    for (int i = 0; i < len; i++) begin
      body.push_back(8'($urandom));
      crc = crc16(body[i], crc);
    end
    // Inverted remainder, high register bit first on the wire
    for (int i = 0; i < 8; i++) begin
      lo[i] = ~crc[15-i];
      hi[i] = ~crc[7-i];
    end
    if (corrupt) begin
      hi[3] = ~hi[3];
    end
    body.push_back(lo);
    body.push_back(hi);
  endtask

  task automatic drive_ulpi(input logic dir, input logic nxt, input logic [7:0] data);
    @(posedge clock);
    #2;
    ulpi_dir_i  = dir;
    ulpi_nxt_i  = nxt;
    ulpi_data_i = data;
  endtask

  // PHY side of one receive, turnaround first and dir dropped at the end
  task automatic send_phy(input logic [7:0] pid_byte, input byte_q_t body);
    drive_ulpi(1'b1, 1'b0, RX_CMD_ACTIVE);
    drive_ulpi(1'b1, 1'b1, pid_byte);
    foreach (body[i]) begin
      while ($urandom % 4 == 0) begin
        drive_ulpi(1'b1, 1'b0, RX_CMD_ACTIVE);
      end
      drive_ulpi(1'b1, 1'b1, body[i]);
    end
    drive_ulpi(1'b0, 1'b0, 8'h00);
  endtask

  task automatic push_beat(input pid_e pid, input logic last, input logic [7:0] data);
    beat_t beat;
    beat.pid  = pid;
    beat.last = last;
    beat.keep = !last;
    beat.data = data;
    if (limit_fill && exp_q.size() >= FIFO_DEPTH) begin
      dropped++;
    end else begin
      exp_q.push_back(beat);
    end
  endtask

  task automatic run_packet(input logic [7:0] pid_byte, input byte_q_t body);
    expect_t e;
    byte_q_t payload;
    e = expected_packet(pid_byte, body, payload);
    if (e.dat) begin
      foreach (payload[i]) begin
        push_beat(pid_e'(pid_byte[3:0]), 1'b0, payload[i]);
      end
      push_beat(pid_e'(pid_byte[3:0]), 1'b1, 8'h00);
    end
    send_phy(pid_byte, body);
    // Strobes follow the end event by one cycle
    @(posedge clock);
    @(negedge clock);
    if (e.has_crc) begin
      exp_crc_err = !e.crc_ok;
    end
    if (e.tok) begin
      exp_addr = e.addr;
      exp_endp = e.endp;
    end
    if (e.sof) begin
      exp_frame = e.frame;
    end
    check_bit("tok_recv_o", e.tok, tok_recv_o);
    check_bit("tok_ping_o", e.ping, tok_ping_o);
    check_bit("sof_recv_o", e.sof, sof_recv_o);
    check_bit("hsk_recv_o", e.hsk, hsk_recv_o);
    check_bit("usb_recv_o", e.usb, usb_recv_o);
    check_bit("crc_valid_o", e.crc_valid, crc_valid_o);
    check_bit("crc_error_o", exp_crc_err, crc_error_o);
    check_bit("dec_idle_o", 1'b1, dec_idle_o);
    check_token(exp_addr, exp_endp, tok_addr_o, tok_endp_o);
    check_frame(exp_frame, sof_frame_o);
  endtask

  task automatic drain_stream;
    while (exp_q.size() != 0) begin
      @(posedge clock);
    end
  endtask

  // Stream monitor, a beat seen here transfers on the next rising edge
  always @(negedge clock) begin
    beat_t head;
    if (!reset && rx_tvalid_o && rx_tready_i) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected stream beat with data %h in test %s", rx_tdata_o, test_name);
        abort_run();
      end else begin
        head = exp_q.pop_front();
        check_bit("rx_tkeep_o", head.keep, rx_tkeep_o);
        check_bit("rx_tlast_o", head.last, rx_tlast_o);
        check_pid("rx_tuser_o", head.pid, rx_tuser_o);
        if (head.keep) begin
          check_byte("rx_tdata_o", head.data, rx_tdata_o);
        end
      end
    end
    if (!reset && overflow_o) begin
      ovf_cnt++;
    end
  end

  initial begin
    repeat (NUM_PACKETS * 2000 + 1000) @(posedge clock);
    $display("Timeout: the run did not finish within its cycle budget in test %s", test_name);
    $display("** FAIL **");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    byte_q_t body;
    pid_e    token_list [4];
    pid_e    hsk_list [3];
    void'($urandom(SEED));
    reset       = 1'b1;
    ulpi_dir_i  = 1'b0;
    ulpi_nxt_i  = 1'b0;
    ulpi_data_i = 8'h00;
    token_list  = '{PID_OUT, PID_IN, PID_SETUP, PID_PING};
    hsk_list    = '{PID_ACK, PID_NAK, PID_STALL};
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b0;
    @(negedge clock);
    test_name = "reset";
    check_bit("rx_tvalid_o", 1'b0, rx_tvalid_o);
    check_bit("overflow_o", 1'b0, overflow_o);
    check_bit("dec_idle_o", 1'b1, dec_idle_o);
    check_bit("crc_error_o", 1'b0, crc_error_o);
    check_pid("rx_tuser_o", PID_RESERVED, rx_tuser_o);

    test_name = "token";
    for (int n = 0; n < 2; n++) begin
      foreach (token_list[k]) begin
        build_token_body(11'($urandom), 1'b0, body);
        run_packet(pid_byte_of(token_list[k], 1'b0), body);
      end
    end

    test_name = "sof_and_bad_crc5";
    for (int n = 0; n < 2; n++) begin
      build_token_body(11'($urandom), 1'b0, body);
      run_packet(pid_byte_of(PID_SOF, 1'b0), body);
      build_token_body(11'($urandom), 1'b1, body);
      run_packet(pid_byte_of(n == 0 ? PID_OUT : PID_SOF, 1'b0), body);
    end

    test_name = "data";
    for (int n = 0; n < 8; n++) begin
      build_data_body(int'($urandom % 13), 1'b0, body);
      run_packet(pid_byte_of(n % 2 == 0 ? PID_DATA0 : PID_DATA1, 1'b0), body);
      drain_stream();
    end

    test_name = "bad_crc16";
    for (int n = 0; n < 2; n++) begin
      build_data_body(int'($urandom % 13), 1'b1, body);
      run_packet(pid_byte_of(n == 0 ? PID_DATA1 : PID_DATA0, 1'b0), body);
      drain_stream();
    end

    test_name = "handshake";
    body = {};
    foreach (hsk_list[k]) begin
      run_packet(pid_byte_of(hsk_list[k], 1'b0), body);
    end
    run_packet(pid_byte_of(PID_ACK, 1'b1), body);
    run_packet(pid_byte_of(PID_DATA0, 1'b1), body);

    test_name = "backpressure";
    ready_mode = 1;
    for (int n = 0; n < 8; n++) begin
      build_data_body(int'($urandom % 13), 1'b0, body);
      run_packet(pid_byte_of(n % 2 == 0 ? PID_DATA1 : PID_DATA0, 1'b0), body);
      drain_stream();
    end

    // Two packets of 12 and 11 entries against a 16-entry FIFO
    test_name = "overflow";
    ready_mode = 0;
    drain_stream();
    check_count("overflow pulses", 0, ovf_cnt);
    limit_fill = 1'b1;
    dropped    = 0;
    ready_mode = 2;
    build_data_body(11, 1'b0, body);
    run_packet(pid_byte_of(PID_DATA0, 1'b0), body);
    build_data_body(10, 1'b0, body);
    run_packet(pid_byte_of(PID_DATA1, 1'b0), body);
    limit_fill = 1'b0;
    ready_mode = 0;
    drain_stream();
    check_count("overflow pulses", dropped, ovf_cnt);

    @(negedge clock);
    check_bit("rx_tvalid_o after drain", 1'b0, rx_tvalid_o);
    $display("** PASS **");
    $finish;
  end

endmodule
